/* filelist.f */
+incdir+logic
logic/forget_gate_pkg.sv
logic/gate_term_if.sv
logic/forget_gate_sequencer.sv
logic/forget_gate_mac.sv
logic/forget_gate_logistic.sv
logic/ntm_forget_gate_vector.sv
tb/tb_ntm_forget_gate_vector.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the forget gate testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

top=tb_ntm_forget_gate_vector
log=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  --top-module "$top" -f filelist.f -o "V$top"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if grep -qx "Test OK" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

/* tb/tb_ntm_forget_gate_vector.sv */
`include "forget_gate_defs.svh"

module tb_ntm_forget_gate_vector;
  timeunit 1ns;
  timeprecision 100ps;
  import forget_gate_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_RUNS     = 8;
  localparam int MAX_GAP      = 3;
  // Single row, 6 random runs of up to 4 x (6+4+4+1), directed run of 14 x 17
  localparam int MAX_STROBES  = 7 + 6 * 60 + 14 * 17;
  localparam int DONE_WAIT    = 12;
  localparam int WATCHDOG_CYCLES = MAX_STROBES * (MAX_GAP + 1) + NUM_RUNS * 20 + 200;

  // Bias-only rows around each sigmoid break point
  localparam logic [15:0] SIG_TARGETS [14] = '{
    16'h7FFF, 16'h8000, 16'd1280, 16'd1279, 16'd608, 16'd607, 16'd256,
    16'd255, 16'd0, 16'(-1), 16'(-255), 16'(-256), 16'(-608), 16'(-1281)
  };

  logic CLK = 1'b0;
  logic RST;
  logic start;
  logic [`FG_SIZE_BITS-1:0] size_x_in, size_w_in, size_l_in;
  logic wx_enable, kr_enable, uh_enable, b_enable;
  logic [`FG_DATA_SIZE-1:0] w_in, x_in, k_in, r_in, u_in, h_in, b_in;
  logic [`FG_DATA_SIZE-1:0] f_out;
  logic f_out_enable;
  logic ready;

  logic [31:0] lfsr_state = 32'h7474;
  int cyc = 0;
  logic started = 1'b0;
  // Term the stimulus is feeding right now
  seq_state_e driving_term = IDLE;
  // Pairs of the row being driven
  logic [15:0] pair_coef [0:63];
  logic [15:0] pair_operand [0:63];
  // Pending results in output order
  logic [15:0] exp_gate_q [$];
  logic        exp_last_q [$];
  int          accept_cyc_q [$];

  always #(CLK_PERIOD / 2) CLK = ~CLK;
  always @(posedge CLK) cyc <= cyc + 1;

  ntm_forget_gate_vector u_ntm_forget_gate_vector (
    .CLK (CLK), .RST (RST), .start (start), .ready (ready),
    .size_x_in (size_x_in), .size_w_in (size_w_in), .size_l_in (size_l_in),
    .wx_enable (wx_enable), .w_in (w_in), .x_in (x_in),
    .kr_enable (kr_enable), .k_in (k_in), .r_in (r_in),
    .uh_enable (uh_enable), .u_in (u_in), .h_in (h_in),
    .b_enable (b_enable), .b_in (b_in),
    .f_out (f_out), .f_out_enable (f_out_enable)
  );

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v, i;
    v = 0;
    for (i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
    return v;
  endfunction

  // Q8.8 value within +-4.0
  function automatic logic [15:0] small_q();
    logic [10:0] r;
    r = 11'(rand_bits(11));
    return {{5{r[10]}}, r};
  endfunction

  function automatic logic [15:0] expected_gate(input int npairs, input logic [15:0] bias);
    int acc, prod, i, y;
    longint mag;
    acc = 0;
    for (i = 0; i < npairs; i++) begin
      prod = int'($signed(pair_coef[i])) * int'($signed(pair_operand[i]));
      // Floor back to Q.8
      acc = acc + (prod >>> `FG_FRAC_BITS);
    end
    acc = acc + int'($signed(bias));
    mag = (acc < 0) ? -longint'(acc) : longint'(acc);
    if (mag >= `FG_SIG_SAT) y = 256;
    else if (mag >= `FG_SIG_MID) y = int'(mag >> 5) + 216;
    else if (mag >= `FG_SIG_LOW) y = int'(mag >> 3) + 160;
    else y = int'(mag >> 2) + 128;
    // Mirrored below zero
    if (acc < 0) y = 256 - y;
    return 16'(y);
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // Outputs sampled on the edge before the DUT updates
  always @(posedge CLK) begin
    if (!RST) begin
      if (!started) begin
        check_value("f_out before start", f_out, 0);
        check_value("f_out_enable before start", f_out_enable, 0);
        check_value("ready before start", ready, 0);
      end else if (f_out_enable) begin
        if (exp_gate_q.size() == 0) begin
          abort_run("Unexpected output: f_out_enable rose with no gate value pending");
        end else begin
          check_value("f_out", f_out, exp_gate_q.pop_front());
          check_value("ready with f_out_enable", ready, exp_last_q.pop_front());
          check_value("bias to f_out_enable latency", cyc - accept_cyc_q.pop_front(), 3);
        end
      end else begin
        check_value("ready without f_out_enable", ready, 0);
      end
    end
  end

  // Bound from the worst-case strobe count
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Timeout in %s: the test did not finish in the expected cycles",
                        driving_term.name()));
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic clear_strobes();
    wx_enable <= 1'b0;
    kr_enable <= 1'b0;
    uh_enable <= 1'b0;
    b_enable  <= 1'b0;
  endtask

  // Term 0 W*x, 1 K*r, 2 U*h, 3 bias
  task automatic set_strobe(input int t, input logic [15:0] c, input logic [15:0] v);
    case (t)
      0: begin
        wx_enable <= 1'b1;
        w_in      <= c;
        x_in      <= v;
      end
      1: begin
        kr_enable <= 1'b1;
        k_in      <= c;
        r_in      <= v;
      end
      2: begin
        uh_enable <= 1'b1;
        u_in      <= c;
        h_in      <= v;
      end
      default: begin
        b_enable <= 1'b1;
        b_in     <= c;
      end
    endcase
  endtask

  task automatic drive_strobe(input int t, input logic [15:0] c, input logic [15:0] v,
                              output int edge_cyc);
    @(posedge CLK);
    edge_cyc = cyc;
    start <= 1'b0;
    clear_strobes();
    set_strobe(t, c, v);
  endtask

  // Idle cycles with foreign strobes and start pulses when noisy
  task automatic insert_gaps(input int cur, input int max_gap, input bit noise);
    int n, k;
    n = (max_gap > 0) ? rand_bits(2) % (max_gap + 1) : 0;
    for (k = 0; k < n; k++) begin
      @(posedge CLK);
      clear_strobes();
      start <= noise ? lfsr_bit() : 1'b0;
      if (noise) set_strobe((cur + 1 + rand_bits(2) % 3) % 4, small_q(), small_q());
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (exp_gate_q.size() != 0 && n < DONE_WAIT) begin
      @(posedge CLK);
      n++;
    end
    if (exp_gate_q.size() != 0) begin
      abort_run("Missing output: gate values still pending after the run ended");
    end
    repeat (2) @(posedge CLK);
  endtask

  task automatic run_rows(input int nx, input int nw, input int nl, input bit directed,
                          input int max_gap, input bit noise);
    int row, t, i, len, npairs, edge_cyc;
    logic [15:0] c, v, bias;
    $display("Run X=%0d W=%0d L=%0d", nx, nw, nl);
    @(posedge CLK);
    started   <= 1'b1;
    start     <= 1'b1;
    size_x_in <= `FG_SIZE_BITS'(nx);
    size_w_in <= `FG_SIZE_BITS'(nw);
    size_l_in <= `FG_SIZE_BITS'(nl);
    for (row = 0; row < nl; row++) begin
      npairs = 0;
      for (t = 0; t < 3; t++) begin
        // U*h also runs over L
        len = (t == 0) ? nx : (t == 1) ? nw : nl;
        driving_term = (t == 0) ? TERM_WX : (t == 1) ? TERM_KR : TERM_UH;
        for (i = 0; i < len; i++) begin
          c = directed ? 16'd0 : small_q();
          v = directed ? 16'd0 : small_q();
          pair_coef[npairs]    = c;
          pair_operand[npairs] = v;
          npairs++;
          insert_gaps(t, max_gap, noise);
          drive_strobe(t, c, v, edge_cyc);
        end
      end
      driving_term = TERM_BIAS;
      bias = directed ? SIG_TARGETS[row] : small_q();
      insert_gaps(3, max_gap, noise);
      drive_strobe(3, bias, 16'd0, edge_cyc);
      exp_gate_q.push_back(expected_gate(npairs, bias));
      exp_last_q.push_back(row == nl - 1);
      // DUT takes the strobe one edge later
      accept_cyc_q.push_back(edge_cyc + 1);
    end
    @(posedge CLK);
    clear_strobes();
    driving_term = IDLE;
    wait_done();
  endtask

  initial begin
    int r;
    RST       = 1'b1;
    start     = 1'b0;
    size_x_in = '0;
    size_w_in = '0;
    size_l_in = '0;
    wx_enable = 1'b0;
    kr_enable = 1'b0;
    uh_enable = 1'b0;
    b_enable  = 1'b0;
    w_in      = '0;
    x_in      = '0;
    k_in      = '0;
    r_in      = '0;
    u_in      = '0;
    h_in      = '0;
    b_in      = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    // Quiet window after reset
    repeat (6) @(posedge CLK);
    run_rows(3, 2, 1, 1'b0, 0, 1'b0);
    for (r = 0; r < 4; r++) begin
      run_rows(rand_bits(8) % 6 + 1, rand_bits(8) % 4 + 1, rand_bits(8) % 4 + 1, 1'b0, 2, 1'b0);
    end
    // Saturation and break points
    run_rows(1, 1, 14, 1'b1, 0, 1'b0);
    for (r = 0; r < 2; r++) begin
      run_rows(rand_bits(8) % 6 + 1, rand_bits(8) % 4 + 1, rand_bits(8) % 4 + 1,
               1'b0, MAX_GAP, 1'b1);
    end
    repeat (4) @(posedge CLK);
    $display("Test OK");
    $finish;
  end

endmodule

/* logic/ntm_forget_gate_vector.sv */
`include "forget_gate_defs.svh"

module ntm_forget_gate_vector (
  input  logic                     CLK,
  input  logic                     RST,

  // Control
  input  logic                     start,
  output logic                     ready,

  // Dimensions, sampled on start
  input  logic [`FG_SIZE_BITS-1:0] size_x_in,
  input  logic [`FG_SIZE_BITS-1:0] size_w_in,
  input  logic [`FG_SIZE_BITS-1:0] size_l_in,

  // Element strobes and data
  input  logic                     wx_enable,
  input  logic [`FG_DATA_SIZE-1:0] w_in,
  input  logic [`FG_DATA_SIZE-1:0] x_in,
  input  logic                     kr_enable,
  input  logic [`FG_DATA_SIZE-1:0] k_in,
  input  logic [`FG_DATA_SIZE-1:0] r_in,
  input  logic                     uh_enable,
  input  logic [`FG_DATA_SIZE-1:0] u_in,
  input  logic [`FG_DATA_SIZE-1:0] h_in,
  input  logic                     b_enable,
  input  logic [`FG_DATA_SIZE-1:0] b_in,

  // Gate value, one per row
  output logic [`FG_DATA_SIZE-1:0] f_out,
  output logic                     f_out_enable
);

  // Execute to result link
  logic                           sum_valid;
  logic signed [`FG_ACC_SIZE-1:0] sum;
  logic                           sum_last;

  // Decode to execute link
  gate_term_if term_bus ();

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  forget_gate_sequencer u_sequencer (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size_x_in (size_x_in),
    .size_w_in (size_w_in),
    .size_l_in (size_l_in),
    .wx_enable (wx_enable),
    .w_in      (w_in),
    .x_in      (x_in),
    .kr_enable (kr_enable),
    .k_in      (k_in),
    .r_in      (r_in),
    .uh_enable (uh_enable),
    .u_in      (u_in),
    .h_in      (h_in),
    .b_enable  (b_enable),
    .b_in      (b_in),
    .term      (term_bus.seq)
  );

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  forget_gate_mac u_mac (
    .CLK       (CLK),
    .RST       (RST),
    .term      (term_bus.mac),
    .sum_valid (sum_valid),
    .sum       (sum),
    .sum_last  (sum_last)
  );

  ////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////

  forget_gate_logistic u_logistic (
    .CLK          (CLK),
    .RST          (RST),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .sum_last     (sum_last),
    .f_out        (f_out),
    .f_out_enable (f_out_enable),
    .ready        (ready)
  );

endmodule

/* logic/forget_gate_logistic.sv */
`include "forget_gate_defs.svh"

module forget_gate_logistic (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           sum_valid,
  input  logic signed [`FG_ACC_SIZE-1:0] sum,
  input  logic                           sum_last,
  output logic        [`FG_DATA_SIZE-1:0] f_out,
  output logic                           f_out_enable,
  output logic                           ready
);

  // 1.0 in Q8.8
  localparam logic [`FG_DATA_SIZE-1:0] ONE_Q = `FG_DATA_SIZE'(1 << `FG_FRAC_BITS);
  // Segment offsets, raw Q8.8
  localparam int SEG_MID_OFS = 216;
  localparam int SEG_LOW_OFS = 160;
  localparam int SEG_CTR_OFS = 128;

  logic [`FG_ACC_SIZE-1:0]  a;
  logic [`FG_DATA_SIZE-1:0] y;
  logic [`FG_DATA_SIZE-1:0] f_next;

  ////////////////////////////////////////////////////////////
  // Piecewise-linear sigmoid
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Magnitude, most negative value still lands in saturation
    a = sum[`FG_ACC_SIZE-1] ? -sum : sum;
    if (a >= `FG_SIG_SAT) begin
      y = ONE_Q;
    end else if (a >= `FG_SIG_MID) begin
      y = `FG_DATA_SIZE'((a >> 5) + SEG_MID_OFS);
    end else if (a >= `FG_SIG_LOW) begin
      y = `FG_DATA_SIZE'((a >> 3) + SEG_LOW_OFS);
    end else begin
      // Slope 1/4 around zero
      y = `FG_DATA_SIZE'((a >> 2) + SEG_CTR_OFS);
    end
    // Mirror for negative sums
    f_next = sum[`FG_ACC_SIZE-1] ? ONE_Q - y : y;
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      f_out        <= '0;
      f_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      f_out_enable <= sum_valid;
      // Pulses with the final row only
      ready        <= sum_valid && sum_last;
      if (sum_valid) f_out <= f_next;
    end
  end

endmodule

/* logic/forget_gate_mac.sv */
`include "forget_gate_defs.svh"

module forget_gate_mac (
  input  logic                           CLK,
  input  logic                           RST,
  gate_term_if.mac                       term,
  output logic                           sum_valid,
  output logic signed [`FG_ACC_SIZE-1:0] sum,
  output logic                           sum_last
);
  import forget_gate_pkg::*;

  logic signed [`FG_ACC_SIZE-1:0] acc;
  logic signed [`FG_ACC_SIZE-1:0] product_full;
  logic signed [`FG_ACC_SIZE-1:0] product_q;
  logic signed [`FG_ACC_SIZE-1:0] bias_ext;
  logic signed [`FG_ACC_SIZE-1:0] addend;
  logic signed [`FG_ACC_SIZE-1:0] acc_base;

  ////////////////////////////////////////////////////////////
  // Product and addend select
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Q8.8 times Q8.8 gives Q16.16, exact in 32 bits
    product_full = $signed(term.coef) * $signed(term.operand);
    // Back to Q.8, floor
    product_q    = product_full >>> `FG_FRAC_BITS;
    bias_ext     = {{(`FG_ACC_SIZE-`FG_DATA_SIZE){term.coef[`FG_DATA_SIZE-1]}}, term.coef};
    addend       = (term.op == OP_BIAS) ? bias_ext : product_q;
    // Row start drops the previous row's sum
    acc_base     = (term.op == OP_LOAD) ? '0 : acc;
  end

  ////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////

  // Wraps on overflow
  always_ff @(posedge CLK) begin
    if (term.term_valid) begin
      acc <= acc_base + addend;
      if (term.op == OP_BIAS) sum_last <= term.last_row;
    end
  end

  // Row done once the bias is in
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= term.term_valid && (term.op == OP_BIAS);
    end
  end

  assign sum = acc;

endmodule

/* logic/forget_gate_sequencer.sv */
`include "forget_gate_defs.svh"

module forget_gate_sequencer (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic [`FG_SIZE_BITS-1:0] size_x_in,
  input  logic [`FG_SIZE_BITS-1:0] size_w_in,
  input  logic [`FG_SIZE_BITS-1:0] size_l_in,
  input  logic                     wx_enable,
  input  logic [`FG_DATA_SIZE-1:0] w_in,
  input  logic [`FG_DATA_SIZE-1:0] x_in,
  input  logic                     kr_enable,
  input  logic [`FG_DATA_SIZE-1:0] k_in,
  input  logic [`FG_DATA_SIZE-1:0] r_in,
  input  logic                     uh_enable,
  input  logic [`FG_DATA_SIZE-1:0] u_in,
  input  logic [`FG_DATA_SIZE-1:0] h_in,
  input  logic                     b_enable,
  input  logic [`FG_DATA_SIZE-1:0] b_in,
  gate_term_if.seq                 term
);
  import forget_gate_pkg::*;

  seq_state_e state;

  // Element index inside a term, row index inside a run
  logic [`FG_SIZE_BITS-1:0] elem_cnt;
  logic [`FG_SIZE_BITS-1:0] row_cnt;

  // Dimensions held for the whole run
  logic [`FG_SIZE_BITS-1:0] size_x;
  logic [`FG_SIZE_BITS-1:0] size_w;
  logic [`FG_SIZE_BITS-1:0] size_l;

  logic                     accept;
  logic [`FG_DATA_SIZE-1:0] coef_sel;
  logic [`FG_DATA_SIZE-1:0] operand_sel;
  logic [`FG_SIZE_BITS-1:0] term_len;
  logic                     elem_last;
  logic                     row_last;

  ////////////////////////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    accept      = 1'b0;
    coef_sel    = w_in;
    operand_sel = x_in;
    term_len    = size_x;
    case (state)
      TERM_WX: begin
        accept = wx_enable;
      end
      TERM_KR: begin
        accept      = kr_enable;
        coef_sel    = k_in;
        operand_sel = r_in;
        term_len    = size_w;
      end
      // U*h runs over L as well
      TERM_UH: begin
        accept      = uh_enable;
        coef_sel    = u_in;
        operand_sel = h_in;
        term_len    = size_l;
      end
      // Single bias element per row
      TERM_BIAS: begin
        accept      = b_enable;
        coef_sel    = b_in;
        operand_sel = '0;
        term_len    = `FG_SIZE_BITS'(1);
      end
      default: begin
        accept = 1'b0;
      end
    endcase
    elem_last = (elem_cnt == term_len - 1'b1);
    row_last  = (row_cnt == size_l - 1'b1);
  end

  ////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= IDLE;
      elem_cnt        <= '0;
      row_cnt         <= '0;
      term.term_valid <= 1'b0;
    end else begin
      // One pair forwarded per accepted strobe
      term.term_valid <= accept;
      if (accept) begin
        elem_cnt <= elem_last ? '0 : elem_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          if (start) begin
            elem_cnt <= '0;
            row_cnt  <= '0;
            state    <= TERM_WX;
          end
        end
        TERM_WX: begin
          if (accept && elem_last) state <= TERM_KR;
        end
        TERM_KR: begin
          if (accept && elem_last) state <= TERM_UH;
        end
        TERM_UH: begin
          if (accept && elem_last) state <= TERM_BIAS;
        end
        TERM_BIAS: begin
          // Next row, or back to IDLE after the last one
          if (accept) begin
            row_cnt <= row_cnt + 1'b1;
            state   <= row_last ? IDLE : TERM_WX;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Operand pair and opcode, qualified by term_valid
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      size_x <= size_x_in;
      size_w <= size_w_in;
      size_l <= size_l_in;
    end
    if (accept) begin
      term.coef     <= coef_sel;
      term.operand  <= operand_sel;
      term.last_row <= (state == TERM_BIAS) && row_last;
      if (state == TERM_BIAS) begin
        term.op <= OP_BIAS;
      end else if (state == TERM_WX && elem_cnt == '0) begin
        // First W*x pair opens the row
        term.op <= OP_LOAD;
      end else begin
        term.op <= OP_MAC;
      end
    end
  end

endmodule

/* logic/gate_term_if.sv */
`include "forget_gate_defs.svh"

interface gate_term_if;
  import forget_gate_pkg::*;

  // One decoded pair per strobe
  logic term_valid;
  acc_op_e op;
  // Weight, or the bias on OP_BIAS
  logic [`FG_DATA_SIZE-1:0] coef;
  // Vector element, unused on OP_BIAS
  logic [`FG_DATA_SIZE-1:0] operand;
  // Closing bias of the final row
  logic last_row;

  // Decode side
  modport seq (
    output term_valid, op, coef, operand, last_row
  );

  // Execute side
  modport mac (
    input term_valid, op, coef, operand, last_row
  );

endinterface

/* logic/forget_gate_pkg.sv */
package forget_gate_pkg;

  ////////////////////////////////////////////////////////////
  // Sequencer states
  ////////////////////////////////////////////////////////////

  // One state per term of the gate sum, in arrival order
  typedef enum logic [2:0] {
    IDLE,
    TERM_WX,
    TERM_KR,
    TERM_UH,
    TERM_BIAS
  } seq_state_e;

  ////////////////////////////////////////////////////////////
  // Accumulator opcodes
  ////////////////////////////////////////////////////////////

  // Load starts a row, bias closes it
  typedef enum logic [1:0] {
    OP_LOAD,
    OP_MAC,
    OP_BIAS
  } acc_op_e;

endpackage

/* logic/forget_gate_defs.svh */
`ifndef FORGET_GATE_DEFS_SVH
`define FORGET_GATE_DEFS_SVH

////////////////////////////////////////////////////////////
// Number format
////////////////////////////////////////////////////////////

// Q8.8 elements
`define FG_DATA_SIZE 16
`define FG_FRAC_BITS 8
// Q24.8 running sum
`define FG_ACC_SIZE 32
// Width of the X, W and L dimension inputs
`define FG_SIZE_BITS 8

////////////////////////////////////////////////////////////
// Sigmoid break points, raw Q8.8
////////////////////////////////////////////////////////////

`define FG_SIG_SAT 1280
`define FG_SIG_MID 608
`define FG_SIG_LOW 256

`endif
